// ==== src/ctrl_macros.svh ====
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

// RV32I major opcodes in bits [6:2] of the instruction
`define OP_LOAD    5'h00
`define OP_I       5'h04
`define OP_AUIPC   5'h05
`define OP_STORE   5'h08
`define OP_R       5'h0c
`define OP_LUI     5'h0d
`define OP_BRANCH  5'h18
`define OP_JALR    5'h19
`define OP_JAL     5'h1b

// ALU operation select as {inst[30], funct3} for R and I forms
`define ALU_ADD    4'd0
`define ALU_SLL    4'd1
`define ALU_SLT    4'd2
`define ALU_SLTU   4'd3
`define ALU_XOR    4'd4
`define ALU_SRL    4'd5
`define ALU_OR     4'd6
`define ALU_AND    4'd7
`define ALU_SUB    4'd8
`define ALU_PASSB  4'd9
`define ALU_SRA    4'd13

// Load size funct3
`define F3_LB      3'd0
`define F3_LH      3'd1
`define F3_LW      3'd2
`define F3_LBU     3'd4
`define F3_LHU     3'd5

// Branch condition funct3
`define F3_BEQ     3'd0
`define F3_BNE     3'd1
`define F3_BLT     3'd4
`define F3_BGE     3'd5
`define F3_BLTU    3'd6
`define F3_BGEU    3'd7

// Writeback source, load format, store size and instruction path selects
`define WB_MEM     2'd0
`define WB_ALU     2'd1
`define WB_PC4     2'd2
`define LD_NONE    3'd7
`define SS_NONE    2'd3
`define INST_SEQ   2'd0
`define INST_REDIR 2'd2

`endif

// ==== src/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

   // One instruction word read either as a register-writing form or as a
   // store/branch form. Bits [11:7] are rd in the first and imm[4:0] in the second
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } rType;
      struct packed {
         logic [6:0] immHi;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] immLo;
         logic [6:0] opcode;
      } sbType;
   } instWord;

endpackage

`default_nettype wire

// ==== src/stageRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module stageRegs (
   input  wire logic            clk,
   input  wire logic            rstN,
   input  wire ctrlPkg::instWord inst,
   input  wire logic            squash,
   output ctrlPkg::instWord     exInst,
   output logic                 exValid,
   output ctrlPkg::instWord     wbInst,
   output logic                 wbValid
);

   // Instruction copies move down one stage per clock
   always_ff @(posedge clk) begin
      exInst <= inst;
      wbInst <= exInst;
   end

   // Valid bits follow the same path and a squash marks the incoming slot dead
   always_ff @(posedge clk) begin
      if (!rstN) begin
         exValid <= 1'b0;
         wbValid <= 1'b0;
      end else begin
         exValid <= !squash;
         wbValid <= exValid;
      end
   end

   // A squash only follows a redirect by a live execute slot
   squashNeedsValid: assert property (
      @(posedge clk) disable iff (!rstN)
      squash |-> exValid
   );

endmodule

`default_nettype wire

// ==== src/squashFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module squashFsm (
   input  wire logic clk,
   input  wire logic rstN,
   input  wire logic pcSel,
   output logic      squash
);

   localparam logic [1:0] fillEx = 2'd0;
   localparam logic [1:0] fillWb = 2'd1;
   localparam logic [1:0] run    = 2'd2;
   localparam logic [1:0] kill   = 2'd3;

   logic [1:0] state;
   logic [1:0] nextState;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= fillEx;
      end else begin
         state <= nextState;
      end
   end

   // Two fill cycles after reset, then one kill slot per redirect
   always_comb begin
      case (state)
         fillEx:      nextState = fillWb;
         fillWb, run: nextState = pcSel ? kill : run;
         kill:        nextState = run;
         default:     nextState = fillEx;
      endcase
   end

   // The redirect cycle itself marks the fall-through fetch dead,
   // so the kill state holds a bubble in execute
   assign squash = pcSel && ((state == fillWb) || (state == run));

   // Execute holds no valid instruction in these states
   noRedirectInBubble: assert property (
      @(posedge clk) disable iff (!rstN)
      ((state == fillEx) || (state == kill)) |-> !pcSel
   );

endmodule

`default_nettype wire

// ==== src/execDecode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_macros.svh"

module execDecode (
   input  wire ctrlPkg::instWord exInst,
   input  wire logic            exValid,
   input  wire logic            brEq,
   input  wire logic            brLt,
   output logic                 pcSel,
   output logic [1:0]           instSel,
   output logic                 brUn,
   output logic                 aSel,
   output logic                 bSel,
   output logic [3:0]           aluSel,
   output logic                 memRw,
   output logic [1:0]           sSel
);

   logic [4:0] exOp;
   logic [2:0] sbFunct3;
   logic       brTaken;

   assign exOp     = exInst.rType.opcode[6:2];
   assign sbFunct3 = exInst.sbType.funct3;

   // Branch condition from the comparator flags
   always_comb begin
      case (sbFunct3)
         `F3_BEQ:  brTaken = brEq;
         `F3_BNE:  brTaken = !brEq;
         `F3_BLT:  brTaken = brLt;
         `F3_BGE:  brTaken = !brLt;
         `F3_BLTU: brTaken = brLt;
         `F3_BGEU: brTaken = !brLt;
         default:  brTaken = 1'b0;
      endcase
   end

   always_comb begin
      // Idle values also serve a dead slot or an unknown opcode
      aSel    = 1'b0;
      bSel    = 1'b0;
      aluSel  = `ALU_ADD;
      brUn    = 1'b0;
      memRw   = 1'b0;
      sSel    = `SS_NONE;
      instSel = `INST_SEQ;
      pcSel   = 1'b0;
      if (exValid) begin
         case (exOp)
            `OP_LOAD: begin
               bSel  = 1'b1;
               memRw = 1'b1;
            end
            `OP_STORE: begin
               bSel  = 1'b1;
               memRw = 1'b1;
               sSel  = sbFunct3[1:0];
            end
            `OP_BRANCH: begin
               // Target is PC plus the B immediate
               aSel    = 1'b1;
               bSel    = 1'b1;
               brUn    = (sbFunct3[2:1] == 2'b11);
               instSel = `INST_REDIR;
               pcSel   = brTaken;
            end
            `OP_JALR: begin
               bSel    = 1'b1;
               instSel = `INST_REDIR;
               pcSel   = 1'b1;
            end
            `OP_JAL: begin
               aSel    = 1'b1;
               bSel    = 1'b1;
               instSel = `INST_REDIR;
               pcSel   = 1'b1;
            end
            `OP_R: begin
               aluSel = {exInst.rType.funct7[5], exInst.rType.funct3};
            end
            `OP_I: begin
               bSel   = 1'b1;
               aluSel = {exInst.rType.funct7[5], exInst.rType.funct3};
            end
            `OP_AUIPC: begin
               aSel = 1'b1;
               bSel = 1'b1;
            end
            `OP_LUI: begin
               bSel   = 1'b1;
               aluSel = `ALU_PASSB;
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/wbDecode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_macros.svh"

module wbDecode (
   input  wire ctrlPkg::instWord wbInst,
   input  wire logic            wbValid,
   output logic                 regWrEn,
   output logic [1:0]           wbSel,
   output logic [2:0]           ldSel
);

   logic [4:0] wbOp;
   logic [2:0] wbFunct3;

   assign wbOp     = wbInst.rType.opcode[6:2];
   assign wbFunct3 = wbInst.rType.funct3;

   always_comb begin
      regWrEn = 1'b0;
      wbSel   = `WB_ALU;
      ldSel   = `LD_NONE;
      if (wbValid) begin
         case (wbOp)
            `OP_LOAD: begin
               regWrEn = 1'b1;
               wbSel   = `WB_MEM;
               // Only legal load sizes reach the load formatter
               case (wbFunct3)
                  `F3_LB, `F3_LH, `F3_LW, `F3_LBU, `F3_LHU: ldSel = wbFunct3;
                  default:                                ldSel = `LD_NONE;
               endcase
            end
            `OP_JAL, `OP_JALR: begin
               // Link register gets the return address
               regWrEn = 1'b1;
               wbSel   = `WB_PC4;
            end
            `OP_R, `OP_I, `OP_AUIPC, `OP_LUI: begin
               regWrEn = 1'b1;
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/forwardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ctrl_macros.svh"

module forwardUnit (
   input  wire ctrlPkg::instWord inst,
   input  wire ctrlPkg::instWord exInst,
   input  wire logic            exValid,
   input  wire ctrlPkg::instWord wbInst,
   input  wire logic            regWrEn,
   output logic                 fwdA1,
   output logic                 fwdB1,
   output logic                 fwdA2,
   output logic                 fwdB2
);

   logic [4:0] wbRd;
   logic       wbRdLive;
   logic [4:0] decOp;
   logic [4:0] exOp;

   // Everything reads rs1 except the upper-immediate forms and JAL
   function automatic logic usesRs1(input logic [4:0] op);
      return !((op == `OP_LUI) || (op == `OP_AUIPC) || (op == `OP_JAL));
   endfunction

   function automatic logic usesRs2(input logic [4:0] op);
      return (op == `OP_R) || (op == `OP_STORE) || (op == `OP_BRANCH);
   endfunction

   // regWrEn already excludes stores, branches and dead slots
   assign wbRd     = wbInst.rType.rd;
   assign wbRdLive = regWrEn && (wbRd != 5'd0);

   assign decOp = inst.rType.opcode[6:2];
   assign exOp  = exInst.rType.opcode[6:2];

   // Decode-stage consumer
   assign fwdA1 = wbRdLive && usesRs1(decOp) && (inst.rType.rs1 == wbRd);
   assign fwdB1 = wbRdLive && usesRs2(decOp) && (inst.rType.rs2 == wbRd);

   // Execute-stage consumer
   assign fwdA2 = wbRdLive && exValid && usesRs1(exOp) && (exInst.rType.rs1 == wbRd);
   assign fwdB2 = wbRdLive && exValid && usesRs2(exOp) && (exInst.rType.rs2 == wbRd);

endmodule

`default_nettype wire

// ==== src/pipeCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeCtrl (
   input  wire logic            clk,
   input  wire logic            rstN,
   input  wire ctrlPkg::instWord inst,
   input  wire logic            brEq,
   input  wire logic            brLt,
   output wire logic            pcSel,
   output wire logic [1:0]      instSel,
   output wire logic            brUn,
   output wire logic            aSel,
   output wire logic            bSel,
   output wire logic [3:0]      aluSel,
   output wire logic            memRw,
   output wire logic [1:0]      sSel,
   output wire logic            regWrEn,
   output wire logic [1:0]      wbSel,
   output wire logic [2:0]      ldSel,
   output wire logic            fwdA1,
   output wire logic            fwdB1,
   output wire logic            fwdA2,
   output wire logic            fwdB2
);

   wire ctrlPkg::instWord exInst;
   wire ctrlPkg::instWord wbInst;
   wire logic             exValid;
   wire logic             wbValid;
   wire logic             squash;

   stageRegs u_stageRegs (
      .clk     (clk),
      .rstN    (rstN),
      .inst    (inst),
      .squash  (squash),
      .exInst  (exInst),
      .exValid (exValid),
      .wbInst  (wbInst),
      .wbValid (wbValid)
   );

   squashFsm u_squashFsm (
      .clk    (clk),
      .rstN   (rstN),
      .pcSel  (pcSel),
      .squash (squash)
   );

   execDecode u_execDecode (
      .exInst  (exInst),
      .exValid (exValid),
      .brEq    (brEq),
      .brLt    (brLt),
      .pcSel   (pcSel),
      .instSel (instSel),
      .brUn    (brUn),
      .aSel    (aSel),
      .bSel    (bSel),
      .aluSel  (aluSel),
      .memRw   (memRw),
      .sSel    (sSel)
   );

   wbDecode u_wbDecode (
      .wbInst  (wbInst),
      .wbValid (wbValid),
      .regWrEn (regWrEn),
      .wbSel   (wbSel),
      .ldSel   (ldSel)
   );

   forwardUnit u_forwardUnit (
      .inst    (inst),
      .exInst  (exInst),
      .exValid (exValid),
      .wbInst  (wbInst),
      .regWrEn (regWrEn),
      .fwdA1   (fwdA1),
      .fwdB1   (fwdB1),
      .fwdA2   (fwdA2),
      .fwdB2   (fwdB2)
   );

endmodule

`default_nettype wire

// ==== testbench/pipeCtrlTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeCtrlTb;

   localparam int expectedLines = 28;
   localparam int maxReadLines  = 200;
   localparam int resetCycles   = 5;
   localparam int resetTimeout  = 50;

   logic        clk;
   logic        rstN;
   logic [31:0] inst;
   logic        brEq;
   logic        brLt;

   wire logic       pcSel;
   wire logic [1:0] instSel;
   wire logic       brUn;
   wire logic       aSel;
   wire logic       bSel;
   wire logic [3:0] aluSel;
   wire logic       memRw;
   wire logic [1:0] sSel;
   wire logic       regWrEn;
   wire logic [1:0] wbSel;
   wire logic [2:0] ldSel;
   wire logic       fwdA1;
   wire logic       fwdB1;
   wire logic       fwdA2;
   wire logic       fwdB2;

   int          errCount;
   int          checkCount;
   logic [31:0] field [0:17];

   pipeCtrl u_dut (
      .clk     (clk),
      .rstN    (rstN),
      .inst    (inst),
      .brEq    (brEq),
      .brLt    (brLt),
      .pcSel   (pcSel),
      .instSel (instSel),
      .brUn    (brUn),
      .aSel    (aSel),
      .bSel    (bSel),
      .aluSel  (aluSel),
      .memRw   (memRw),
      .sSel    (sSel),
      .regWrEn (regWrEn),
      .wbSel   (wbSel),
      .ldSel   (ldSel),
      .fwdA1   (fwdA1),
      .fwdB1   (fwdB1),
      .fwdA2   (fwdA2),
      .fwdB2   (fwdB2)
   );

   // 20 ns period
   always #10 clk = ~clk;

   task automatic compareValue(input string name, input logic [31:0] expVal,
                               input logic [31:0] actVal);
      checkCount++;
      assert (actVal === expVal) else begin
         $display("FAILED t=%0t %s expected %0h actual %0h", $time, name, expVal, actVal);
         errCount++;
      end
   endtask

   // Field order follows the stimulus file columns
   task automatic checkOutputs();
      compareValue("pcSel", field[3], {31'd0, pcSel});
      compareValue("instSel", field[4], {30'd0, instSel});
      compareValue("brUn", field[5], {31'd0, brUn});
      compareValue("aSel", field[6], {31'd0, aSel});
      compareValue("bSel", field[7], {31'd0, bSel});
      compareValue("aluSel", field[8], {28'd0, aluSel});
      compareValue("memRw", field[9], {31'd0, memRw});
      compareValue("sSel", field[10], {30'd0, sSel});
      compareValue("regWrEn", field[11], {31'd0, regWrEn});
      compareValue("wbSel", field[12], {30'd0, wbSel});
      compareValue("ldSel", field[13], {29'd0, ldSel});
      compareValue("fwdA1", field[14], {31'd0, fwdA1});
      compareValue("fwdB1", field[15], {31'd0, fwdB1});
      compareValue("fwdA2", field[16], {31'd0, fwdA2});
      compareValue("fwdB2", field[17], {31'd0, fwdB2});
   endtask

   initial begin
      int                fd;
      int                cycleCount;
      int                readCount;
      int                linesApplied;
      int                matched;
      logic [8*200-1:0]  lineBuf;
      clk          = 1'b0;
      rstN         = 1'b0;
      inst         = 32'd0;
      brEq         = 1'b0;
      brLt         = 1'b0;
      errCount     = 0;
      checkCount   = 0;
      cycleCount   = 0;
      readCount    = 0;
      linesApplied = 0;

      // Hold reset across five rising edges
      while (cycleCount < resetCycles && $time < resetTimeout * 20) begin
         @(posedge clk);
         cycleCount++;
      end
      if (cycleCount < resetCycles) begin
         $display("Timed out while holding reset");
         errCount++;
      end

      fd = $fopen("testbench/ctrlStim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file testbench/ctrlStim.txt");
         errCount++;
      end else begin
         #2;
         rstN = 1'b1;
         while (!$feof(fd) && readCount < maxReadLines) begin
            readCount++;
            lineBuf = '0;
            if ($fgets(lineBuf, fd) != 0) begin
               matched = $sscanf(lineBuf,
                  "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  field[0], field[1], field[2], field[3], field[4], field[5],
                  field[6], field[7], field[8], field[9], field[10], field[11],
                  field[12], field[13], field[14], field[15], field[16], field[17]);
               if (matched == 18) begin
                  inst = field[0];
                  brEq = field[1][0];
                  brLt = field[2][0];
                  linesApplied++;
                  // Sample just before the next rising edge
                  #16;
                  checkOutputs();
                  @(posedge clk);
                  #2;
               end else if (matched > 0) begin
                  $display("Stimulus line %0d has only %0d of 18 columns", readCount, matched);
                  errCount++;
               end
            end
         end
         if (readCount >= maxReadLines) begin
            $display("Timed out before reaching the end of the stimulus file");
            errCount++;
         end
         $fclose(fd);
         if (linesApplied != expectedLines) begin
            $display("Stimulus file is short, %0d of %0d cycles applied",
                     linesApplied, expectedLines);
            errCount++;
         end
      end

      $display("Checks: %0d, errors: %0d", checkCount, errCount);
      if (errCount == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/ctrlStim.txt ====
// inst brEq brLt | pcSel instSel brUn aSel bSel aluSel memRw sSel | regWrEn wbSel ldSel
// | fwdA1 fwdB1 fwdA2 fwdB2, one line per cycle after reset, all hex
00500093 0 0 0 0 0 0 0 0 0 3 0 1 7 0 0 0 0
400081B3 0 0 0 0 0 0 1 0 0 3 0 1 7 0 0 0 0
00108233 0 0 0 0 0 0 0 8 0 3 1 1 7 1 1 1 0
0081A283 0 0 0 0 0 0 0 0 0 3 1 1 7 1 0 0 0
00522223 0 0 0 0 0 0 1 0 1 3 1 1 7 1 0 0 0
00428463 0 0 0 0 0 0 1 0 1 2 1 0 2 1 0 0 1
00429463 0 0 0 2 0 1 1 0 0 3 0 1 7 0 0 0 0
00522223 0 0 1 2 0 1 1 0 0 3 0 1 7 0 0 0 0
0042C463 0 0 0 0 0 0 0 0 0 3 0 1 7 0 0 0 0
0042D463 0 0 0 2 0 1 1 0 0 3 0 1 7 0 0 0 0
0042E463 0 1 0 2 0 1 1 0 0 3 0 1 7 0 0 0 0
0042F463 1 0 0 2 1 1 1 0 0 3 0 1 7 0 0 0 0
00428463 0 1 0 2 1 1 1 0 0 3 0 1 7 0 0 0 0
0081A283 1 0 1 2 0 1 1 0 0 3 0 1 7 0 0 0 0
010000EF 0 0 0 0 0 0 0 0 0 3 0 1 7 0 0 0 0
00108233 0 0 1 2 0 1 1 0 0 3 0 1 7 0 0 0 0
00008337 0 0 0 0 0 0 0 0 0 3 1 2 7 0 0 0 0
000083E7 0 0 0 0 0 0 1 9 0 3 0 1 7 0 0 0 0
00630433 0 0 1 2 0 0 1 0 0 3 1 1 7 1 1 0 0
00738493 0 0 0 0 0 0 0 0 0 3 1 2 7 1 0 0 0
00000517 0 0 0 0 0 0 1 0 0 3 0 1 7 0 0 0 0
4034D593 0 0 0 0 0 1 1 0 0 3 1 1 7 1 0 0 0
00A50033 0 0 0 0 0 0 1 D 0 3 1 1 7 1 1 0 0
00004603 0 0 0 0 0 0 0 0 0 3 1 1 7 0 0 0 0
000000B3 0 0 0 0 0 0 1 0 1 3 1 1 7 0 0 0 0
00C61023 0 0 0 0 0 0 0 0 0 3 1 0 4 1 1 0 0
00000013 0 0 0 0 0 0 1 0 1 1 1 1 7 0 0 0 0
00000013 0 0 0 0 0 0 1 0 0 3 0 1 7 0 0 0 0

// ==== tb.f ====
+incdir+src
src/ctrlPkg.sv
src/stageRegs.sv
src/squashFsm.sv
src/execDecode.sv
src/wbDecode.sv
src/forwardUnit.sv
src/pipeCtrl.sv
testbench/pipeCtrlTb.sv
